// File: sap1_pkg.sv
package sap1_pkg;

    localparam int DATA_W     = 8;
    localparam int ADDR_W     = 4;
    localparam int FRAME_BITS = 40;     // a, b, acc, pc byte, sng_en, operand, state

    typedef logic [DATA_W-1:0] data_t;  // Bus and register value
    typedef logic [ADDR_W-1:0] addr_t;  // Memory address, PC or operand
    typedef logic [2:0]        prog_sel_t;

    typedef enum logic [3:0] {
        OP_LDA = 4'h0,
        OP_ADD = 4'h1,
        OP_SUB = 4'h2,
        OP_SNG = 4'h3,
        OP_OUT = 4'hE,
        OP_HLT = 4'hF
    } opcode_t;

    typedef enum logic [2:0] {T0, T1, T2, T3, T4, T5} t_state_t;

    typedef struct packed {
        logic sng_en;
        logic hlt;
        logic pc_inc;
        logic pc_en;       // PC drives the bus
        logic mar_load;
        logic mem_en;      // ROM drives the bus
        logic ir_load;
        logic ir_en;       // IR drives the bus
        logic a_load;
        logic b_load;
        logic alu_sub;
        logic acc_load;
    } ctrl_word_t;

    // Sent MSB first, so a goes out on the wire before everything else
    typedef struct packed {
        data_t    a;
        data_t    b;
        data_t    acc;
        logic [3:0] pc_pad;  // Always zero
        addr_t    pc;
        logic     sng_en;
        addr_t    operand;
        t_state_t state;
    } status_frame_t;

endpackage

// File: sap1_controller.sv
`timescale 1ns/100ps

module sap1_controller (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  restart,
    input  logic                  step,
    input  sap1_pkg::opcode_t     opcode,
    output sap1_pkg::ctrl_word_t  ctrl,
    output sap1_pkg::t_state_t    state
);
    import sap1_pkg::*;

    // Ring of six T-states, frozen by HLT
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= T0;
        end else if (restart) begin
            state <= T0;
        end else if (step && !ctrl.hlt) begin
            if (state == T5) begin
                state <= T0;
            end else begin
                state <= t_state_t'(state + 3'd1);
            end
        end
    end

    always_comb begin
        ctrl = '0;
        case (state)
            T0: begin
                ctrl.pc_en    = 1'b1;  // Fetch address from PC
                ctrl.mar_load = 1'b1;
            end
            T1: ctrl.pc_inc = 1'b1;
            T2: begin
                ctrl.mem_en  = 1'b1;   // Instruction into IR
                ctrl.ir_load = 1'b1;
            end
            T3: begin
                case (opcode)
                    OP_LDA, OP_ADD, OP_SUB: begin
                        ctrl.ir_en    = 1'b1;  // Operand address to MAR
                        ctrl.mar_load = 1'b1;
                    end
                    OP_HLT:  ctrl.hlt    = 1'b1;
                    OP_SNG:  ctrl.sng_en = 1'b1;
                    default: ctrl = '0;        // OUT has nothing to drive
                endcase
            end
            T4: begin
                if (opcode == OP_LDA) begin
                    ctrl.mem_en = 1'b1;
                    ctrl.a_load = 1'b1;
                end else if (opcode == OP_ADD || opcode == OP_SUB) begin
                    ctrl.mem_en = 1'b1;
                    ctrl.b_load = 1'b1;
                end
            end
            T5: begin
                ctrl.acc_load = (opcode == OP_ADD) || (opcode == OP_SUB);
                ctrl.alu_sub  = (opcode == OP_SUB);
            end
            default: ctrl = '0;
        endcase
    end

    a_state_range: assert property (@(posedge clk) disable iff (reset) state <= T5)
        else $error("controller state out of range");

endmodule

// File: sap1_datapath.sv
`timescale 1ns/100ps

module sap1_datapath (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  restart,
    input  logic                  step,
    input  sap1_pkg::ctrl_word_t  ctrl,
    input  sap1_pkg::data_t       rom_data,
    output sap1_pkg::addr_t       mar,
    output sap1_pkg::opcode_t     opcode,
    output sap1_pkg::addr_t       operand,
    output sap1_pkg::addr_t       pc,
    output sap1_pkg::data_t       a,
    output sap1_pkg::data_t       b,
    output sap1_pkg::data_t       acc
);
    import sap1_pkg::*;

    data_t bus;
    data_t ir_q;
    data_t alu_out;

    // Bus source mux, the controller never enables two at once
    always_comb begin
        if (ctrl.pc_en) begin
            bus = {4'h0, pc};
        end else if (ctrl.mem_en) begin
            bus = rom_data;
        end else if (ctrl.ir_en) begin
            bus = ir_q;
        end else begin
            bus = '0;
        end
    end

    assign alu_out = ctrl.alu_sub ? a - b : a + b;  // Wraps modulo 256

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc   <= '0;
            mar  <= '0;
            ir_q <= '0;
            a    <= '0;
            b    <= '0;
            acc  <= '0;
        end else if (restart) begin
            pc   <= '0;
            mar  <= '0;
            ir_q <= '0;
            a    <= '0;
            b    <= '0;
            acc  <= '0;
        end else if (step) begin
            if (ctrl.pc_inc && !ctrl.hlt) begin
                pc <= pc + 4'd1;   // Wraps at 16
            end
            if (ctrl.mar_load) begin
                mar <= bus[3:0];
            end
            if (ctrl.ir_load) begin
                ir_q <= bus;
            end
            if (ctrl.a_load) begin
                a <= bus;
            end
            if (ctrl.b_load) begin
                b <= bus;
            end
            if (ctrl.acc_load) begin
                acc <= alu_out;
            end
        end
    end

    assign opcode  = opcode_t'(ir_q[7:4]);
    assign operand = ir_q[3:0];

    a_bus_single_driver: assert property (@(posedge clk) disable iff (reset)
        $onehot0({ctrl.pc_en, ctrl.mem_en, ctrl.ir_en}))
        else $error("more than one bus driver enabled");

endmodule

// File: program_rom.sv
`timescale 1ns/100ps

module program_rom (
    input  sap1_pkg::prog_sel_t  sel,
    input  sap1_pkg::addr_t      addr,
    output sap1_pkg::data_t      data
);
    import sap1_pkg::*;

    localparam data_t VAL_A = 8'h0A;  // Operand word at address 15
    localparam data_t VAL_B = 8'h04;  // Operand word at address 14

    logic  is_song;
    addr_t song_num;

    function automatic data_t instr(opcode_t op, addr_t arg);
        instr = {op, arg};
    endfunction

    always_comb begin
        is_song  = 1'b1;
        song_num = '0;
        case (sel)
            3'b010:  song_num = 4'd2;
            3'b011:  song_num = 4'd3;
            3'b100:  song_num = 4'd4;
            3'b111:  song_num = 4'd5;
            default: is_song = 1'b0;  // Add or subtract program
        endcase
    end

    always_comb begin
        data = '0;
        if (is_song) begin
            case (addr)
                4'd0:    data = instr(OP_SNG, song_num);
                4'd1:    data = instr(OP_HLT, 4'd0);
                default: data = '0;
            endcase
        end else begin
            case (addr)
                4'd0:    data = instr(OP_LDA, 4'd15);
                4'd1:    data = instr((sel == 3'b001) ? OP_SUB : OP_ADD, 4'd14);
                4'd2:    data = instr(OP_OUT, 4'd0);
                4'd3:    data = instr(OP_SNG, 4'd0);
                4'd4:    data = instr(OP_HLT, 4'd0);
                4'd14:   data = VAL_B;
                4'd15:   data = VAL_A;
                default: data = '0;
            endcase
        end
    end

endmodule

// File: spi_frame_tx.sv
`timescale 1ns/100ps

module spi_frame_tx #(
    parameter int SPI_DIV = 200     // clk cycles per SCLK half period
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  sap1_pkg::status_frame_t  frame,
    output logic                     sclk,
    output logic                     mosi,
    output logic                     cs_n,
    output logic                     busy
);
    import sap1_pkg::*;

    localparam int DIV_W = $clog2(SPI_DIV + 1);
    localparam int BIT_W = $clog2(FRAME_BITS);

    logic [DIV_W-1:0]      div_cnt;
    logic [BIT_W-1:0]      bit_cnt;
    logic [FRAME_BITS-1:0] shift_q;
    logic                  half_done;
    logic                  fall;

    assign half_done = busy && (div_cnt == DIV_W'(SPI_DIV - 1));
    assign fall      = half_done && sclk;

    // Payload shifter, loaded on accepted start
    always_ff @(posedge clk) begin
        if (!busy && start) begin
            shift_q <= frame;
        end else if (fall) begin
            shift_q <= {shift_q[FRAME_BITS-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            div_cnt <= '0;
            bit_cnt <= '0;
            sclk    <= 1'b0;
            mosi    <= 1'b0;
            cs_n    <= 1'b1;
            busy    <= 1'b0;
        end else if (!busy) begin
            if (start) begin
                div_cnt <= '0;
                bit_cnt <= '0;
                mosi    <= frame[FRAME_BITS-1];  // First bit ready before SCLK rises
                cs_n    <= 1'b0;
                busy    <= 1'b1;
            end
        end else if (half_done) begin
            div_cnt <= '0;
            sclk    <= ~sclk;
            if (fall) begin
                if (bit_cnt == BIT_W'(FRAME_BITS - 1)) begin
                    mosi <= 1'b0;   // Frame complete
                    cs_n <= 1'b1;
                    busy <= 1'b0;
                end else begin
                    mosi    <= shift_q[FRAME_BITS-2];
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    a_sclk_idle_low: assert property (@(posedge clk) disable iff (reset) cs_n |-> !sclk)
        else $error("sclk active while cs_n is high");

endmodule

// File: sap1_top.sv
`timescale 1ns/100ps

module sap1_top #(
    parameter int STEP_DIV = 100_000,  // clk cycles per machine step
    parameter int SPI_DIV  = 200
) (
    input  logic                 clk,
    input  logic                 reset,
    input  sap1_pkg::prog_sel_t  program_sel,
    output logic                 sclk,
    output logic                 mosi,
    output logic                 cs_n,
    output logic                 halted
);
    import sap1_pkg::*;

    localparam int STEP_W = $clog2(STEP_DIV + 1);

    logic [STEP_W-1:0] step_cnt;
    logic              step;
    logic              step_d;
    logic              restart;
    logic              start;
    logic              busy;
    prog_sel_t         sel_q;
    ctrl_word_t        ctrl;
    t_state_t          state;
    opcode_t           opcode;
    addr_t             mar, operand, pc;
    data_t             rom_data, a, b, acc;
    status_frame_t     frame;

    // Select register, any change restarts the program
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sel_q   <= '0;
            restart <= 1'b0;
        end else begin
            sel_q   <= program_sel;
            restart <= (program_sel != sel_q);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            step_cnt <= '0;
            step     <= 1'b0;
            step_d   <= 1'b0;
        end else begin
            step_d <= step && !restart;  // Frame start follows the step by one cycle
            if (restart) begin
                step_cnt <= '0;
                step     <= 1'b0;
            end else if (step_cnt == STEP_W'(STEP_DIV - 1)) begin
                step_cnt <= '0;
                step     <= 1'b1;
            end else begin
                step_cnt <= step_cnt + 1'b1;
                step     <= 1'b0;
            end
        end
    end

    assign halted = ctrl.hlt;
    assign start  = step_d && !halted && !busy;  // Skipped if the last frame is still out
    assign frame  = '{a: a, b: b, acc: acc, pc_pad: 4'h0, pc: pc, sng_en: ctrl.sng_en,
                      operand: operand, state: state};

    sap1_controller u_ctrl (.clk(clk), .reset(reset), .restart(restart), .step(step),
                            .opcode(opcode), .ctrl(ctrl), .state(state));

    sap1_datapath u_dp (.clk(clk), .reset(reset), .restart(restart), .step(step),
                        .ctrl(ctrl), .rom_data(rom_data), .mar(mar), .opcode(opcode),
                        .operand(operand), .pc(pc), .a(a), .b(b), .acc(acc));

    program_rom u_rom (.sel(sel_q), .addr(mar), .data(rom_data));

    spi_frame_tx #(.SPI_DIV(SPI_DIV)) u_spi (.clk(clk), .reset(reset), .start(start),
                                             .frame(frame), .sclk(sclk), .mosi(mosi),
                                             .cs_n(cs_n), .busy(busy));

endmodule

// File: tb_sap1_top.sv
`timescale 1ns/100ps

module tb_sap1_top;
    import sap1_pkg::*;

    localparam int STEP_DIV    = 400;
    localparam int SPI_DIV     = 2;
    localparam int WATCHDOG_NS = 2 * 12 * 40 * STEP_DIV * 8;  // 12 runs of 40 steps, doubled

    logic      clk;
    logic      reset;
    prog_sel_t program_sel;
    logic      sclk, mosi, cs_n, halted;

    int     errors, tests_done, tests_failed, errors_at_start, seed;
    int     frame_count, rx_bits, m_state;
    logic [FRAME_BITS-1:0] rx_shift;
    status_frame_t rx_frame;
    addr_t     m_pc, m_mar, sng_operand;
    data_t     m_ir, m_a, m_b, m_acc;
    prog_sel_t m_sel;
    bit        m_halted, sng_seen;

    sap1_top #(.STEP_DIV(STEP_DIV), .SPI_DIV(SPI_DIV)) dut (.clk(clk), .reset(reset),
        .program_sel(program_sel), .sclk(sclk), .mosi(mosi), .cs_n(cs_n), .halted(halted));

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // SPI receiver, MSB first on rising sclk
    initial begin
        rx_bits = 0;
        frame_count = 0;
        forever begin
            @(posedge sclk);
            if (!cs_n) begin
                rx_shift = {rx_shift[FRAME_BITS-2:0], mosi};
                rx_bits++;
                if (rx_bits == FRAME_BITS) begin
                    rx_frame = status_frame_t'(rx_shift);
                    rx_bits = 0;
                    frame_count++;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("ERRORS FOUND");
        $finish;
    end

    // Copy of the six program tables
    function automatic data_t rom_byte(prog_sel_t sel, addr_t addr);
        data_t song;
        case (sel)
            3'd2:    song = 8'h32;
            3'd3:    song = 8'h33;
            3'd4:    song = 8'h34;
            3'd7:    song = 8'h35;
            default: song = 8'h00;
        endcase
        if (song != 8'h00) return (addr == 4'd0) ? song : (addr == 4'd1) ? 8'hF0 : 8'h00;
        case (addr)
            4'd0:    return 8'h0F;                           // LDA 15
            4'd1:    return (sel == 3'd1) ? 8'h2E : 8'h1E;  // SUB 14 or ADD 14
            4'd2:    return 8'hE0;
            4'd3:    return 8'h30;
            4'd4:    return 8'hF0;
            4'd14:   return 8'h04;
            4'd15:   return 8'h0A;
            default: return 8'h00;
        endcase
    endfunction

    function automatic prog_sel_t random_new_select();
        prog_sel_t sel;
        sel = prog_sel_t'($random(seed));
        if (sel == m_sel) sel = sel + 3'd1;  // A change is needed for a restart
        return sel;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("Mismatch %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        end
    endtask

    task automatic model_reset(input prog_sel_t sel);
        m_sel = sel;
        m_state = 0;
        {m_pc, m_mar, m_ir, m_a, m_b, m_acc} = '0;
        m_halted = 1'b0;
        sng_seen = 1'b0;
    endtask

    // One T-state of the reference machine
    task automatic model_step();
        logic [3:0] op;
        op = m_ir[7:4];
        case (m_state)
            0: m_mar = m_pc;
            1: m_pc = m_pc + 4'd1;
            2: m_ir = rom_byte(m_sel, m_mar);
            3: if (op == OP_LDA || op == OP_ADD || op == OP_SUB) m_mar = m_ir[3:0];
            4: begin
                if (op == OP_LDA) m_a = rom_byte(m_sel, m_mar);
                else if (op == OP_ADD || op == OP_SUB) m_b = rom_byte(m_sel, m_mar);
            end
            default: begin
                if (op == OP_ADD) m_acc = m_a + m_b;
                else if (op == OP_SUB) m_acc = m_a - m_b;
            end
        endcase
        if (!(m_state == 3 && op == OP_HLT)) m_state = (m_state == 5) ? 0 : m_state + 1;
        m_halted = (m_state == 3) && (m_ir[7:4] == OP_HLT);
    endtask

    task automatic compare_frame();
        compare_value("a", m_a, rx_frame.a);
        compare_value("b", m_b, rx_frame.b);
        compare_value("acc", m_acc, rx_frame.acc);
        compare_value("pc_pad", 0, rx_frame.pc_pad);
        compare_value("pc", m_pc, rx_frame.pc);
        compare_value("sng_en", m_state == 3 && m_ir[7:4] == OP_SNG, rx_frame.sng_en);
        compare_value("operand", m_ir[3:0], rx_frame.operand);
        compare_value("state", m_state, rx_frame.state);
        if (rx_frame.state == T3 && rx_frame.sng_en) begin
            sng_seen = 1'b1;
            sng_operand = rx_frame.operand;
        end
    endtask

    task automatic wait_frame(output bit got);
        int old;
        int n;
        old = frame_count;
        n = 0;
        while (frame_count == old && n < 2 * STEP_DIV) begin
            @(negedge clk);
            n++;
        end
        got = (frame_count != old);
        if (!got) begin
            errors++;
            $display("No SPI frame arrived within two step periods");
        end
    endtask

    task automatic wait_halted();
        int n;
        n = 0;
        while (!halted && n < 2 * STEP_DIV) begin
            @(negedge clk);
            n++;
        end
        if (!halted) begin
            errors++;
            $display("halted did not rise after the HLT instruction");
        end
    endtask

    task automatic run_steps(input int count);
        int n;
        bit got;
        n = 0;
        while (!m_halted && n < count) begin
            model_step();
            n++;
            if (m_halted) begin
                wait_halted();
            end else begin
                wait_frame(got);
                if (got) compare_frame();
            end
        end
    endtask

    task automatic select_program(input prog_sel_t sel);
        @(negedge clk);
        program_sel = sel;
        model_reset(sel);
    endtask

    task automatic end_test(input string name);
        tests_done++;
        if (errors == errors_at_start) begin
            $display("Test %s passed", name);
        end else begin
            tests_failed++;
            $display("Test %s failed with %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    initial begin
        int n;
        int quiet;
        bit bad;
        prog_sel_t sel;
        seed = 32'he30b;
        errors = 0;
        tests_done = 0;
        tests_failed = 0;
        errors_at_start = 0;
        reset = 1'b1;
        program_sel = 3'd0;
        model_reset(3'd0);
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        n = 0;
        while (cs_n && n < 2 * STEP_DIV) begin  // Idle until the first frame
            @(negedge clk);
            compare_value("sclk", 0, sclk);
            compare_value("halted", 0, halted);
            n++;
        end
        if (cs_n) begin
            errors++;
            $display("The first frame never started");
        end
        end_test("reset idle");

        run_steps(40);
        compare_value("acc", 8'h0E, rx_frame.acc);
        compare_value("b", 8'h04, rx_frame.b);
        compare_value("a", 8'h0A, rx_frame.a);
        compare_value("halted", 1, halted);
        end_test("add program");

        select_program(3'd1);
        run_steps(40);
        compare_value("acc", 8'h06, rx_frame.acc);
        compare_value("halted", 1, halted);
        end_test("subtract program");

        for (int i = 0; i < 4; i++) begin
            select_program((i == 3) ? 3'd7 : prog_sel_t'(i + 2));
            run_steps(40);
            if (!sng_seen) begin
                errors++;
                $display("No frame in T3 with sng_en set for song %0d", i + 2);
            end
            compare_value("operand", i + 2, sng_operand);
            compare_value("halted", 1, halted);
        end
        select_program(3'd5 + prog_sel_t'($random(seed) & 1));  // Unlisted code runs add
        run_steps(40);
        compare_value("acc", 8'h0E, rx_frame.acc);
        compare_value("halted", 1, halted);
        end_test("song and unlisted selects");

        for (int i = 0; i < 4; i++) begin
            select_program(random_new_select());
            run_steps(1);
            compare_value("state", T1, rx_frame.state);
            compare_value("a", 0, rx_frame.a);
            compare_value("b", 0, rx_frame.b);
            compare_value("acc", 0, rx_frame.acc);
            run_steps(($random(seed) & 7) + 1);
        end
        sel = random_new_select();
        select_program(sel);
        run_steps(40);
        end_test("mid-run program changes");

        quiet = frame_count;
        bad = 1'b0;
        for (n = 0; n < 3 * STEP_DIV; n++) begin
            @(negedge clk);
            if (!cs_n || !halted) bad = 1'b1;
        end
        if (bad) begin
            errors++;
            $display("cs_n fell or halted dropped after the processor halted");
        end
        compare_value("frame_count", quiet, frame_count);
        end_test("quiet after halt");

        $display("%0d tests run, %0d failed, %0d errors", tests_done, tests_failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: sap1_top.f
sap1_pkg.sv
sap1_controller.sv
sap1_datapath.sv
program_rom.sv
spi_frame_tx.sv
sap1_top.sv
tb_sap1_top.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f sap1_top.f \
    --top-module tb_sap1_top -o sim_sap1
./obj_dir/sim_sap1 | tee sim.log
if grep -qx "NO ERRORS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
